// File: src.f
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/tmr_voter.sv
hdl/ex_mult.sv
hdl/ex_wb_ctrl.sv
hdl/ex_stage_ft.sv
dv/clk_rst_gen.sv
dv/ex_stage_ft_tb.sv

// File: Makefile
# Verilator simulation of the execute stage testbench
VERILATOR ?= verilator
TOP       ?= ex_stage_ft_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# the run passes only if the log holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/ex_stage_ft_tb.sv
// table-driven testbench for the fault-tolerant execute stage
// each row goes through the DUT in turn, the first mismatch stops the run
`timescale 1ns/100ps

module ex_stage_ft_tb
  import ex_pkg::*;
();

  localparam int unsigned CLK_PERIOD  = 40;
  localparam int unsigned DRIVE_DELAY = 1;
  localparam int unsigned N_ROWS      = 23;
  // worst row is one multiply plus a few spare cycles
  localparam int unsigned WATCHDOG_CYCLES = N_ROWS * (MULT_CYCLES + 4) + 8;

  // row kinds
  localparam int KIND_ALU  = 0;
  localparam int KIND_MULT = 1;
  localparam int KIND_CSR  = 2;
  localparam int KIND_LOAD = 3;
  // which alu copies get a flipped operand a
  localparam int CORR_NONE = 0;
  localparam int CORR_ONE  = 1;
  localparam int CORR_ALL  = 2;

  logic      clk;
  logic      rst_n;
  logic      alu_en, mult_en, csr_access, lsu_en;
  alu_op_t   alu_op_0, alu_op_1, alu_op_2;
  word_t     op_a_0, op_a_1, op_a_2;
  word_t     op_b_0, op_b_1, op_b_2;
  word_t     op_c, mult_a, mult_b, csr_rdata, lsu_rdata;
  logic      lsu_ready_ex, lsu_err, branch_in_ex, wb_ready;
  logic      rf_alu_we, rf_we;
  reg_addr_t rf_alu_waddr, rf_waddr;
  // DUT outputs
  logic      fw_we, wb_we, branch_decision, mult_multicycle;
  reg_addr_t fw_waddr, wb_waddr;
  word_t     fw_wdata, wb_wdata, jump_target;
  logic      ex_ready, ex_valid, err_det, err_corr;

  //////////////////////////////////////////////////////////////////////
  // stimulus table, expected columns filled by the reference model
  //////////////////////////////////////////////////////////////////////
  string     row_name [N_ROWS];
  int        row_kind [N_ROWS];
  int        row_corrupt [N_ROWS];
  alu_op_t   row_op [N_ROWS];
  word_t     row_a [N_ROWS];
  word_t     row_b [N_ROWS];
  // side word: jump target, csr read data or load data
  word_t     row_c [N_ROWS];
  word_t     row_mask_1 [N_ROWS];
  word_t     row_mask_2 [N_ROWS];
  logic      row_lsu_err [N_ROWS];
  word_t     row_exp_data [N_ROWS];
  logic      row_exp_cmp [N_ROWS];
  logic      row_exp_det [N_ROWS];
  logic      row_exp_corr [N_ROWS];
  int        n_rows;
  int        err_count;
  word_t     rng_state;
  string     cur_test;

  clk_rst_gen #(.CLK_PERIOD(CLK_PERIOD), .RST_CYCLES(3)) i_clk_rst_gen (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  ex_stage_ft i_ex_stage_ft (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .alu_en_i              (alu_en),
    .alu_operator_0_i      (alu_op_0),
    .alu_operator_1_i      (alu_op_1),
    .alu_operator_2_i      (alu_op_2),
    .alu_operand_a_0_i     (op_a_0),
    .alu_operand_a_1_i     (op_a_1),
    .alu_operand_a_2_i     (op_a_2),
    .alu_operand_b_0_i     (op_b_0),
    .alu_operand_b_1_i     (op_b_1),
    .alu_operand_b_2_i     (op_b_2),
    .alu_operand_c_i       (op_c),
    .mult_en_i             (mult_en),
    .mult_operand_a_i      (mult_a),
    .mult_operand_b_i      (mult_b),
    .csr_access_i          (csr_access),
    .csr_rdata_i           (csr_rdata),
    .lsu_en_i              (lsu_en),
    .lsu_rdata_i           (lsu_rdata),
    .lsu_ready_ex_i        (lsu_ready_ex),
    .lsu_err_i             (lsu_err),
    .branch_in_ex_i        (branch_in_ex),
    .regfile_alu_we_i      (rf_alu_we),
    .regfile_alu_waddr_i   (rf_alu_waddr),
    .regfile_we_i          (rf_we),
    .regfile_waddr_i       (rf_waddr),
    .wb_ready_i            (wb_ready),
    .regfile_alu_we_fw_o   (fw_we),
    .regfile_alu_waddr_fw_o(fw_waddr),
    .regfile_alu_wdata_fw_o(fw_wdata),
    .regfile_we_wb_o       (wb_we),
    .regfile_waddr_wb_o    (wb_waddr),
    .regfile_wdata_wb_o    (wb_wdata),
    .jump_target_o         (jump_target),
    .branch_decision_o     (branch_decision),
    .mult_multicycle_o     (mult_multicycle),
    .ex_ready_o            (ex_ready),
    .ex_valid_o            (ex_valid),
    .err_detected_alu_o    (err_det),
    .err_corrected_alu_o   (err_corr)
  );

  //////////////////////////////////////////////////////////////////////
  // random numbers and reference model
  //////////////////////////////////////////////////////////////////////
  function automatic word_t xorshift32(input word_t x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic cmp_model(input alu_op_t op, input word_t a, input word_t b);
    case (op)
      ALU_SLT:  return $signed(a) < $signed(b);
      ALU_SLTU: return a < b;
      ALU_EQ:   return a == b;
      ALU_NE:   return a != b;
      default:  return 1'b0;
    endcase
  endfunction

  function automatic word_t alu_model(input alu_op_t op, input word_t a, input word_t b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return word_t'($signed(a) >>> b[4:0]);
      // compares give the bit zero-extended
      default: return word_t'(cmp_model(op, a, b));
    endcase
  endfunction

  // bit is set when two or three inputs have it set
  function automatic word_t majority3(input word_t x, input word_t y, input word_t z);
    word_t m;
    for (int i = 0; i < XLEN; i++) begin
      m[i] = (int'(x[i]) + int'(y[i]) + int'(z[i])) >= 2;
    end
    return m;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // table setup
  //////////////////////////////////////////////////////////////////////
  task automatic add_row(input string name, input int kind, input alu_op_t op,
                         input int corrupt, input logic lsu_err_flag);
    row_name[n_rows]    = name;
    row_kind[n_rows]    = kind;
    row_op[n_rows]      = op;
    row_corrupt[n_rows] = corrupt;
    row_lsu_err[n_rows] = lsu_err_flag;
    row_a[n_rows]       = next_rand();
    row_b[n_rows]       = next_rand();
    row_c[n_rows]       = next_rand();
    // xorshift never yields zero, and two draws in a row differ
    row_mask_1[n_rows]  = next_rand();
    row_mask_2[n_rows]  = next_rand();
    n_rows++;
  endtask

  task automatic build_table();
    n_rows = 0;
    add_row("add", KIND_ALU, ALU_ADD, CORR_NONE, 1'b0);
    add_row("sub", KIND_ALU, ALU_SUB, CORR_NONE, 1'b0);
    add_row("and", KIND_ALU, ALU_AND, CORR_NONE, 1'b0);
    add_row("or", KIND_ALU, ALU_OR, CORR_NONE, 1'b0);
    add_row("xor", KIND_ALU, ALU_XOR, CORR_NONE, 1'b0);
    add_row("sll", KIND_ALU, ALU_SLL, CORR_NONE, 1'b0);
    add_row("srl", KIND_ALU, ALU_SRL, CORR_NONE, 1'b0);
    add_row("sra", KIND_ALU, ALU_SRA, CORR_NONE, 1'b0);
    add_row("slt", KIND_ALU, ALU_SLT, CORR_NONE, 1'b0);
    add_row("sltu", KIND_ALU, ALU_SLTU, CORR_NONE, 1'b0);
    add_row("ne", KIND_ALU, ALU_NE, CORR_NONE, 1'b0);
    add_row("eq_equal", KIND_ALU, ALU_EQ, CORR_NONE, 1'b0);
    row_b[n_rows-1] = row_a[n_rows-1];
    // negative a against positive b
    add_row("slt_negative", KIND_ALU, ALU_SLT, CORR_NONE, 1'b0);
    row_a[n_rows-1] = row_a[n_rows-1] | 32'h8000_0000;
    row_b[n_rows-1] = row_b[n_rows-1] & 32'h7fff_ffff;
    // single faulty copy, ops where any operand flip shows in the result
    add_row("add_copy1_fault", KIND_ALU, ALU_ADD, CORR_ONE, 1'b0);
    add_row("sub_copy1_fault", KIND_ALU, ALU_SUB, CORR_ONE, 1'b0);
    add_row("xor_copy1_fault", KIND_ALU, ALU_XOR, CORR_ONE, 1'b0);
    add_row("add_three_way", KIND_ALU, ALU_ADD, CORR_ALL, 1'b0);
    add_row("xor_three_way", KIND_ALU, ALU_XOR, CORR_ALL, 1'b0);
    add_row("mul_random", KIND_MULT, ALU_ADD, CORR_NONE, 1'b0);
    add_row("mul_negative", KIND_MULT, ALU_ADD, CORR_NONE, 1'b0);
    row_a[n_rows-1] = 32'hffff_fffd;
    add_row("csr_over_alu", KIND_CSR, ALU_ADD, CORR_NONE, 1'b0);
    add_row("load_ok", KIND_LOAD, ALU_ADD, CORR_NONE, 1'b0);
    add_row("load_error", KIND_LOAD, ALU_ADD, CORR_NONE, 1'b1);
  endtask

  task automatic compute_expected();
    word_t a;
    word_t b;
    alu_op_t op;
    for (int i = 0; i < N_ROWS; i++) begin
      a  = row_a[i];
      b  = row_b[i];
      op = row_op[i];
      row_exp_cmp[i]  = cmp_model(op, a, b);
      // one bad copy is outvoted, three different copies cannot be
      row_exp_det[i]  = row_corrupt[i] != CORR_NONE;
      row_exp_corr[i] = row_corrupt[i] == CORR_ONE;
      case (row_kind[i])
        KIND_ALU: begin
          if (row_corrupt[i] == CORR_ALL) begin
            row_exp_data[i] = majority3(alu_model(op, a, b),
                                        alu_model(op, a ^ row_mask_1[i], b),
                                        alu_model(op, a ^ row_mask_2[i], b));
          end else begin
            row_exp_data[i] = alu_model(op, a, b);
          end
        end
        KIND_MULT: row_exp_data[i] = a * b;
        default:   row_exp_data[i] = row_c[i];
      endcase
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // drive and check
  //////////////////////////////////////////////////////////////////////
  task automatic idle_inputs();
    alu_en       = 1'b0;
    alu_op_0     = ALU_ADD;
    alu_op_1     = ALU_ADD;
    alu_op_2     = ALU_ADD;
    op_a_0       = '0;
    op_a_1       = '0;
    op_a_2       = '0;
    op_b_0       = '0;
    op_b_1       = '0;
    op_b_2       = '0;
    op_c         = '0;
    mult_en      = 1'b0;
    mult_a       = '0;
    mult_b       = '0;
    csr_access   = 1'b0;
    csr_rdata    = '0;
    lsu_en       = 1'b0;
    lsu_rdata    = '0;
    lsu_ready_ex = 1'b1;
    lsu_err      = 1'b0;
    branch_in_ex = 1'b0;
    rf_alu_we    = 1'b0;
    rf_alu_waddr = '0;
    rf_we        = 1'b0;
    rf_waddr     = '0;
    wb_ready     = 1'b1;
  endtask

  task automatic report_mismatch(input string what, input word_t exp, input word_t act);
    err_count++;
    $display("error: %s %s expected %h actual %h", cur_test, what, exp, act);
    $display("Test failed");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic compare_word(input string what, input word_t exp, input word_t act);
    assert (act === exp) else report_mismatch(what, exp, act);
  endtask

  task automatic expect_flag(input string what, input logic exp, input logic act);
    assert (act === exp) else report_mismatch(what, word_t'(exp), word_t'(act));
  endtask

  // alu rows and csr rows, single cycle
  task automatic run_alu_row(input int i);
    word_t     a_1;
    word_t     a_2;
    reg_addr_t addr;
    logic      fw_en;
    a_1   = row_a[i];
    a_2   = row_a[i];
    addr  = reg_addr_t'(i + 1);
    // write enable alternates so a stuck forward enable shows up
    fw_en = (i % 2) == 0;
    if (row_corrupt[i] != CORR_NONE) a_1 = row_a[i] ^ row_mask_1[i];
    if (row_corrupt[i] == CORR_ALL) a_2 = row_a[i] ^ row_mask_2[i];
    alu_en       = 1'b1;
    alu_op_0     = row_op[i];
    alu_op_1     = row_op[i];
    alu_op_2     = row_op[i];
    op_a_0       = row_a[i];
    op_a_1       = a_1;
    op_a_2       = a_2;
    op_b_0       = row_b[i];
    op_b_1       = row_b[i];
    op_b_2       = row_b[i];
    op_c         = row_c[i];
    csr_access   = row_kind[i] == KIND_CSR;
    csr_rdata    = row_c[i];
    rf_alu_we    = fw_en;
    rf_alu_waddr = addr;
    @(negedge clk);
    compare_word("forward data", row_exp_data[i], fw_wdata);
    compare_word("forward address", word_t'(addr), word_t'(fw_waddr));
    expect_flag("forward enable", fw_en, fw_we);
    compare_word("jump target", row_c[i], jump_target);
    expect_flag("ex_ready", 1'b1, ex_ready);
    expect_flag("ex_valid", 1'b1, ex_valid);
    expect_flag("error detected", row_exp_det[i], err_det);
    expect_flag("error corrected", row_exp_corr[i], err_corr);
    if (row_op[i] inside {ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE}) begin
      expect_flag("branch decision", row_exp_cmp[i], branch_decision);
    end
  endtask

  // operands held until the stage reports ready
  task automatic run_mult_row(input int i);
    int   cycles;
    logic seen_busy;
    cycles    = 0;
    seen_busy = 1'b0;
    mult_en   = 1'b1;
    mult_a    = row_a[i];
    mult_b    = row_b[i];
    @(negedge clk);
    while (!ex_ready) begin
      seen_busy = seen_busy | mult_multicycle;
      cycles++;
      @(negedge clk);
    end
    expect_flag("multicycle seen", 1'b1, seen_busy);
    compare_word("multiply latency", word_t'(MULT_CYCLES + 1), word_t'(cycles));
    expect_flag("ex_valid", 1'b1, ex_valid);
    compare_word("product", row_exp_data[i], fw_wdata);
  endtask

  task automatic run_load_row(input int i);
    reg_addr_t addr;
    addr      = reg_addr_t'(i + 1);
    lsu_en    = 1'b1;
    lsu_rdata = row_c[i];
    lsu_err   = row_lsu_err[i];
    rf_we     = 1'b1;
    rf_waddr  = addr;
    @(negedge clk);
    expect_flag("ex_valid", 1'b1, ex_valid);
    // EX/WB register loads on this edge, load data stays on the bus
    @(posedge clk);
    #(DRIVE_DELAY);
    lsu_en  = 1'b0;
    lsu_err = 1'b0;
    rf_we   = 1'b0;
    @(negedge clk);
    expect_flag("writeback enable", !row_lsu_err[i], wb_we);
    if (!row_lsu_err[i]) begin
      compare_word("writeback address", word_t'(addr), word_t'(wb_waddr));
    end
    compare_word("writeback data", row_exp_data[i], wb_wdata);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////
  initial begin : stimulus
    err_count = 0;
    rng_state = 32'h43ca_99a1;
    idle_inputs();
    build_table();
    compute_expected();
    @(posedge rst_n);
    for (int i = 0; i < N_ROWS; i++) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      idle_inputs();
      cur_test = row_name[i];
      case (row_kind[i])
        KIND_MULT: run_mult_row(i);
        KIND_LOAD: run_load_row(i);
        default:   run_alu_row(i);
      endcase
    end
    if (err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: rows not finished after %0d clock cycles", WATCHDOG_CYCLES);
    $display("Test failed");
    $fatal(1, "simulation stopped by the watchdog");
  end

endmodule

// File: dv/clk_rst_gen.sv
// clock and reset source for the testbench
// free-running clock, active-low reset released after a few cycles
`timescale 1ns/100ps

module clk_rst_gen #(
  parameter int unsigned CLK_PERIOD = 40,
  parameter int unsigned RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(CLK_PERIOD / 2) clk_o = ~clk_o;
  end

  // release just after an edge, clear of the flops
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

// File: hdl/ex_stage_ft.sv
// fault-tolerant execute stage top level
// three voted ALU copies, multicycle multiplier and writeback control
`timescale 1ns/100ps

module ex_stage_ft
  import ex_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  // triplicated alu inputs, one set per copy
  input  logic      alu_en_i,
  input  alu_op_t   alu_operator_0_i,
  input  alu_op_t   alu_operator_1_i,
  input  alu_op_t   alu_operator_2_i,
  input  word_t     alu_operand_a_0_i,
  input  word_t     alu_operand_a_1_i,
  input  word_t     alu_operand_a_2_i,
  input  word_t     alu_operand_b_0_i,
  input  word_t     alu_operand_b_1_i,
  input  word_t     alu_operand_b_2_i,
  input  word_t     alu_operand_c_i,
  // multiplier, operands voted upstream
  input  logic      mult_en_i,
  input  word_t     mult_operand_a_i,
  input  word_t     mult_operand_b_i,
  input  logic      csr_access_i,
  input  word_t     csr_rdata_i,
  input  logic      lsu_en_i,
  input  word_t     lsu_rdata_i,
  input  logic      lsu_ready_ex_i,
  input  logic      lsu_err_i,
  input  logic      branch_in_ex_i,
  input  logic      regfile_alu_we_i,
  input  reg_addr_t regfile_alu_waddr_i,
  input  logic      regfile_we_i,
  input  reg_addr_t regfile_waddr_i,
  input  logic      wb_ready_i,
  output logic      regfile_alu_we_fw_o,
  output reg_addr_t regfile_alu_waddr_fw_o,
  output word_t     regfile_alu_wdata_fw_o,
  output logic      regfile_we_wb_o,
  output reg_addr_t regfile_waddr_wb_o,
  output word_t     regfile_wdata_wb_o,
  output word_t     jump_target_o,
  output logic      branch_decision_o,
  output logic      mult_multicycle_o,
  output logic      ex_ready_o,
  output logic      ex_valid_o,
  output logic      err_detected_alu_o,
  output logic      err_corrected_alu_o
);

  word_t alu_result_0;
  word_t alu_result_1;
  word_t alu_result_2;
  logic  alu_cmp_0;
  logic  alu_cmp_1;
  logic  alu_cmp_2;
  word_t alu_result;
  logic  alu_cmp;
  logic  res_err_det;
  logic  res_err_corr;
  logic  cmp_err_det;
  logic  cmp_err_corr;
  word_t mult_result;
  logic  mult_ready;

  //////////////////////////////////////////////////////////////////////
  // triple ALU and voters
  //////////////////////////////////////////////////////////////////////
  ex_alu i_alu_0 (
    .operator_i  (alu_operator_0_i),  .operand_a_i (alu_operand_a_0_i),
    .operand_b_i (alu_operand_b_0_i), .result_o    (alu_result_0),
    .cmp_result_o(alu_cmp_0)
  );

  ex_alu i_alu_1 (
    .operator_i  (alu_operator_1_i),  .operand_a_i (alu_operand_a_1_i),
    .operand_b_i (alu_operand_b_1_i), .result_o    (alu_result_1),
    .cmp_result_o(alu_cmp_1)
  );

  ex_alu i_alu_2 (
    .operator_i  (alu_operator_2_i),  .operand_a_i (alu_operand_a_2_i),
    .operand_b_i (alu_operand_b_2_i), .result_o    (alu_result_2),
    .cmp_result_o(alu_cmp_2)
  );

  tmr_voter #(.WIDTH(XLEN)) i_res_voter (
    .in_0_i        (alu_result_0), .in_1_i         (alu_result_1),
    .in_2_i        (alu_result_2), .voted_o        (alu_result),
    .err_detected_o(res_err_det),  .err_corrected_o(res_err_corr)
  );

  tmr_voter #(.WIDTH(1)) i_cmp_voter (
    .in_0_i        (alu_cmp_0),   .in_1_i         (alu_cmp_1),
    .in_2_i        (alu_cmp_2),   .voted_o        (alu_cmp),
    .err_detected_o(cmp_err_det), .err_corrected_o(cmp_err_corr)
  );

  // branch outputs
  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = alu_operand_c_i;

  //////////////////////////////////////////////////////////////////////
  // multiplier and writeback control
  //////////////////////////////////////////////////////////////////////
  ex_mult i_mult (
    .clk         (clk),              .rst_n     (rst_n),
    .enable_i    (mult_en_i),        .op_a_i    (mult_operand_a_i),
    .op_b_i      (mult_operand_b_i), .ex_ready_i(ex_ready_o),
    .result_o    (mult_result),      .ready_o   (mult_ready),
    .multicycle_o(mult_multicycle_o)
  );

  // the 1-bit voter always corrects what it detects, so its flags just OR in
  ex_wb_ctrl i_ex_wb_ctrl (
    .clk                   (clk),                    .rst_n              (rst_n),
    .alu_en_i              (alu_en_i),               .mult_en_i          (mult_en_i),
    .csr_access_i          (csr_access_i),           .lsu_en_i           (lsu_en_i),
    .alu_result_i          (alu_result),             .mult_result_i      (mult_result),
    .csr_rdata_i           (csr_rdata_i),            .lsu_rdata_i        (lsu_rdata_i),
    .mult_ready_i          (mult_ready),             .lsu_ready_ex_i     (lsu_ready_ex_i),
    .lsu_err_i             (lsu_err_i),              .wb_ready_i         (wb_ready_i),
    .branch_in_ex_i        (branch_in_ex_i),         .regfile_alu_we_i   (regfile_alu_we_i),
    .regfile_alu_waddr_i   (regfile_alu_waddr_i),    .regfile_we_i       (regfile_we_i),
    .regfile_waddr_i       (regfile_waddr_i),
    .alu_err_detected_i    (res_err_det | cmp_err_det),
    .alu_err_corrected_i   (res_err_corr | cmp_err_corr),
    .regfile_alu_we_fw_o   (regfile_alu_we_fw_o),    .regfile_we_wb_o    (regfile_we_wb_o),
    .regfile_alu_waddr_fw_o(regfile_alu_waddr_fw_o), .regfile_waddr_wb_o (regfile_waddr_wb_o),
    .regfile_alu_wdata_fw_o(regfile_alu_wdata_fw_o), .regfile_wdata_wb_o (regfile_wdata_wb_o),
    .ex_ready_o            (ex_ready_o),             .ex_valid_o         (ex_valid_o),
    .err_detected_alu_o    (err_detected_alu_o),     .err_corrected_alu_o(err_corrected_alu_o)
  );

endmodule

// File: hdl/ex_wb_ctrl.sv
// execute stage control: ALU write port mux, ready/valid stall logic
// and the EX/WB register feeding the load write port
`timescale 1ns/100ps

module ex_wb_ctrl
  import ex_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      alu_en_i,
  input  logic      mult_en_i,
  input  logic      csr_access_i,
  input  logic      lsu_en_i,
  input  word_t     alu_result_i,
  input  word_t     mult_result_i,
  input  word_t     csr_rdata_i,
  input  word_t     lsu_rdata_i,
  input  logic      mult_ready_i,
  input  logic      lsu_ready_ex_i,
  input  logic      lsu_err_i,
  input  logic      wb_ready_i,
  input  logic      branch_in_ex_i,
  input  logic      regfile_alu_we_i,
  input  reg_addr_t regfile_alu_waddr_i,
  input  logic      regfile_we_i,
  input  reg_addr_t regfile_waddr_i,
  input  logic      alu_err_detected_i,
  input  logic      alu_err_corrected_i,
  output logic      regfile_alu_we_fw_o,
  output reg_addr_t regfile_alu_waddr_fw_o,
  output word_t     regfile_alu_wdata_fw_o,
  output logic      regfile_we_wb_o,
  output reg_addr_t regfile_waddr_wb_o,
  output word_t     regfile_wdata_wb_o,
  output logic      ex_ready_o,
  output logic      ex_valid_o,
  output logic      err_detected_alu_o,
  output logic      err_corrected_alu_o
);

  // all units able to hand over this cycle
  logic      units_ready;
  logic      lsu_we_q;
  reg_addr_t lsu_waddr_q;

  //////////////////////////////////////////////////////////////////////
  // forwarding port, csr over mult over alu
  //////////////////////////////////////////////////////////////////////
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  always_comb begin
    if (csr_access_i) regfile_alu_wdata_fw_o = csr_rdata_i;
    else if (mult_en_i) regfile_alu_wdata_fw_o = mult_result_i;
    else if (alu_en_i) regfile_alu_wdata_fw_o = alu_result_i;
    else regfile_alu_wdata_fw_o = '0;
  end

  // voter flags only mean something with an alu op in flight
  assign err_detected_alu_o  = alu_en_i & alu_err_detected_i;
  assign err_corrected_alu_o = alu_en_i & alu_err_corrected_i;

  //////////////////////////////////////////////////////////////////////
  // stall logic
  //////////////////////////////////////////////////////////////////////
  // single-cycle alu is always ready
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  // branches resolve here without needing WB
  assign ex_ready_o  = units_ready | branch_in_ex_i;
  // valid goes right, ready goes left, so no ex_ready term
  assign ex_valid_o  = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  //////////////////////////////////////////////////////////////////////
  // EX/WB register, load write port
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q    <= 1'b0;
      lsu_waddr_q <= '0;
    end else if (ex_valid_o) begin
      // faulting load never writes back
      lsu_we_q <= regfile_we_i & ~lsu_err_i;
      if (regfile_we_i & ~lsu_err_i) lsu_waddr_q <= regfile_waddr_i;
    end else if (wb_ready_i) begin
      // nothing new, flush the slot
      lsu_we_q <= 1'b0;
    end
  end

  assign regfile_we_wb_o    = lsu_we_q;
  assign regfile_waddr_wb_o = lsu_waddr_q;
  assign regfile_wdata_wb_o = lsu_rdata_i;

  assert property (@(posedge clk) disable iff (!rst_n)
      (ex_valid_o && lsu_err_i) |=> !regfile_we_wb_o)
    else $error("ex_wb_ctrl: write back after a load error");

endmodule

// File: hdl/ex_mult.sv
// iterative shift-add multiplier, low 32 bits of the product
// fixed latency, result held in DONE until the stage moves on
`timescale 1ns/100ps

module ex_mult
  import ex_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  enable_i,
  input  word_t op_a_i,
  input  word_t op_b_i,
  input  logic  ex_ready_i,
  output word_t result_o,
  output logic  ready_o,
  output logic  multicycle_o
);

  localparam int unsigned CNT_W = $clog2(MULT_CYCLES);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(MULT_CYCLES - 1);

  mult_state_t      state_q;
  mult_state_t      state_d;
  logic [CNT_W-1:0] cnt_q;
  // partial product, shifted multiplicand, remaining multiplier bits
  word_t            acc_q;
  word_t            mcand_q;
  word_t            mplier_q;

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      MULT_IDLE: if (enable_i) state_d = MULT_BUSY;
      MULT_BUSY: if (cnt_q == CNT_LAST) state_d = MULT_DONE;
      // stay here while the stage is stalled
      MULT_DONE: if (ex_ready_i) state_d = MULT_IDLE;
      default:   state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      // iteration counter runs only while busy
      if (state_q == MULT_BUSY) cnt_q <= cnt_q + 1'b1;
      else cnt_q <= '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (state_q == MULT_IDLE && enable_i) begin
      acc_q    <= '0;
      mcand_q  <= op_a_i;
      mplier_q <= op_b_i;
    end else if (state_q == MULT_BUSY) begin
      if (mplier_q[0]) acc_q <= acc_q + mcand_q;
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  assign result_o     = acc_q;
  // idle and unused, or result waiting
  assign ready_o      = (state_q == MULT_IDLE && !enable_i) || (state_q == MULT_DONE);
  assign multicycle_o = state_q == MULT_BUSY;

  // ID stage holds the voted operands until ex_ready
  assert property (@(posedge clk) disable iff (!rst_n)
      (state_q == MULT_BUSY) |-> ($stable(op_a_i) && $stable(op_b_i)))
    else $error("ex_mult: operands changed during a multiply");

endmodule

// File: hdl/tmr_voter.sv
// bitwise three-way majority voter with error reporting
// WIDTH is set per instance, 32 for alu results and 1 for the compare bit
`timescale 1ns/100ps

module tmr_voter #(
  parameter int unsigned WIDTH = 32
) (
  input  logic [WIDTH-1:0] in_0_i,
  input  logic [WIDTH-1:0] in_1_i,
  input  logic [WIDTH-1:0] in_2_i,
  output logic [WIDTH-1:0] voted_o,
  output logic             err_detected_o,
  output logic             err_corrected_o
);

  // at least one pair of whole words matches
  logic pair_match;

  // per-bit majority, also used when no two words agree
  assign voted_o = (in_0_i & in_1_i) | (in_0_i & in_2_i) | (in_1_i & in_2_i);

  // any copy off from the others
  assign err_detected_o = (in_0_i != in_1_i) | (in_0_i != in_2_i);

  assign pair_match = (in_0_i == in_1_i) | (in_0_i == in_2_i) | (in_1_i == in_2_i);

  // only a single faulty copy can be masked
  assign err_corrected_o = err_detected_o & pair_match;

  // a corrected word must be one that two copies really produced
  always_comb begin
    assert final (!err_corrected_o || (err_detected_o &&
        (voted_o == in_0_i || voted_o == in_1_i || voted_o == in_2_i)))
      else $error("tmr_voter: corrected flag without a valid two-copy result");
  end

endmodule

// File: hdl/ex_alu.sv
// single ALU copy, purely combinational
// the top level instantiates three of these behind a majority voter
`timescale 1ns/100ps

module ex_alu
  import ex_pkg::*;
(
  input  alu_op_t operator_i,
  input  word_t   operand_a_i,
  input  word_t   operand_b_i,
  output word_t   result_o,
  output logic    cmp_result_o
);

  // shift amount from the low bits of operand b
  logic [$clog2(XLEN)-1:0] shamt;
  logic                    lt_signed;
  logic                    lt_unsigned;
  logic                    is_equal;

  assign shamt       = operand_b_i[$clog2(XLEN)-1:0];
  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_unsigned = operand_a_i < operand_b_i;
  assign is_equal    = operand_a_i == operand_b_i;

  // comparison bit, low for non-compare operators
  always_comb begin
    case (operator_i)
      ALU_SLT:  cmp_result_o = lt_signed;
      ALU_SLTU: cmp_result_o = lt_unsigned;
      ALU_EQ:   cmp_result_o = is_equal;
      ALU_NE:   cmp_result_o = ~is_equal;
      default:  cmp_result_o = 1'b0;
    endcase
  end

  // result word
  always_comb begin
    case (operator_i)
      ALU_ADD: result_o = operand_a_i + operand_b_i;
      ALU_SUB: result_o = operand_a_i - operand_b_i;
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ALU_SLL: result_o = operand_a_i << shamt;
      ALU_SRL: result_o = operand_a_i >> shamt;
      // arithmetic shift keeps the sign
      ALU_SRA: result_o = word_t'($signed(operand_a_i) >>> shamt);
      // compares return the bit zero-extended
      ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE: result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
      default: result_o = '0;
    endcase
  end

  // decode upstream must never hand over an unknown operator code
  always_comb begin
    assert final ($isunknown(operator_i) || operator_i inside {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE})
      else $error("ex_alu: undefined operator code %h", operator_i);
  end

endmodule

// File: hdl/ex_pkg.sv
// shared types and constants of the fault-tolerant execute stage
// imported by every RTL module and by the testbench reference model
package ex_pkg;

  // data path and register file widths
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 6;
  localparam int unsigned ALU_OP_W   = 4;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [ALU_OP_W-1:0]   alu_op_t;

  //////////////////////////////////////////////////////////////////////
  // alu operator codes
  //////////////////////////////////////////////////////////////////////
  localparam alu_op_t ALU_ADD  = 4'h0;
  localparam alu_op_t ALU_SUB  = 4'h1;
  localparam alu_op_t ALU_AND  = 4'h2;
  localparam alu_op_t ALU_OR   = 4'h3;
  localparam alu_op_t ALU_XOR  = 4'h4;
  localparam alu_op_t ALU_SLL  = 4'h5;
  localparam alu_op_t ALU_SRL  = 4'h6;
  localparam alu_op_t ALU_SRA  = 4'h7;
  // compare group, result also on the comparison bit
  localparam alu_op_t ALU_SLT  = 4'h8;
  localparam alu_op_t ALU_SLTU = 4'h9;
  localparam alu_op_t ALU_EQ   = 4'hA;
  localparam alu_op_t ALU_NE   = 4'hB;

  //////////////////////////////////////////////////////////////////////
  // multiplier
  //////////////////////////////////////////////////////////////////////
  // one shift-add step per operand bit
  localparam int unsigned MULT_CYCLES = 32;

  typedef enum logic [1:0] {
    MULT_IDLE,
    MULT_BUSY,
    MULT_DONE
  } mult_state_t;

endpackage
